//--- cipher_regs.sv
// Register block; KV_ENTRIES must be a power of two, low two address bits are ignored
`timescale 1ns/100ps
module cipher_regs #(
  parameter int KV_ENTRIES = 32
) (
  input  logic                       clk,
  input  logic                       reset_n,
  input  crypto_pkg::reg_req_t       req_i,
  output crypto_pkg::reg_rsp_t       rsp_o,
  output crypto_pkg::kv_ctrl_t       kv_ctrl_o,
  input  logic                       kv_ready_i,
  input  logic                       kv_done_i,
  input  crypto_pkg::kv_err_e        kv_err_i,
  input  crypto_pkg::sideload_key_t  sideload_i,
  output logic                       start_o,
  output logic                       decrypt_o,
  output logic [63:0]                block_o,
  output logic [127:0]               key_o,
  input  logic                       eng_busy_i,
  input  logic                       eng_done_i,
  input  logic [63:0]                result_i
);

  localparam logic [crypto_pkg::KV_ENTRY_W-1:0] ENTRY_MASK =
      crypto_pkg::KV_ENTRY_W'(KV_ENTRIES - 1);

  logic [crypto_pkg::REG_ADDR_W-1:0] word_addr;
  logic addr_bad;
  logic ro_hit;
  logic is_dout;
  logic wr_en;
  logic rd_en;
  logic out_valid;
  logic idle;
  logic [63:0] res_now;
  logic [crypto_pkg::DATA_W-1:0] rd_data;

  // Control state
  logic ov_q;
  logic kv_valid_q;
  crypto_pkg::kv_ctrl_t kv_ctrl_q;

  // Payload
  logic [crypto_pkg::KEY_WORDS-1:0][crypto_pkg::DATA_W-1:0] key_q;
  logic [1:0][crypto_pkg::DATA_W-1:0] din_q;
  logic [63:0] dout_q;

  // ==========================================================================
  // Address decode
  // ==========================================================================
  assign word_addr = {req_i.addr[crypto_pkg::REG_ADDR_W-1:2], 2'b00};
  assign addr_bad  = (req_i.addr >= crypto_pkg::ADDR_LIMIT);
  assign is_dout   = (word_addr == crypto_pkg::ADDR_DOUT0) ||
                     (word_addr == crypto_pkg::ADDR_DOUT1);
  assign ro_hit    = is_dout || (word_addr == crypto_pkg::ADDR_STATUS) ||
                     (word_addr == crypto_pkg::ADDR_KV_STATUS);

  // Bad writes change nothing
  assign wr_en = req_i.dv && req_i.write && !addr_bad && !ro_hit;
  assign rd_en = req_i.dv && !req_i.write && !addr_bad;

  // Start only from an idle engine
  assign start_o   = wr_en && (word_addr == crypto_pkg::ADDR_CTRL) && req_i.wdata[0] &&
                     !eng_busy_i;
  assign decrypt_o = req_i.wdata[1];
  assign block_o   = {din_q[1], din_q[0]};
  // Side-loaded key wins while valid
  assign key_o     = sideload_i.valid ? sideload_i.key : key_q;

  // Result is visible in the done cycle itself
  assign out_valid = ov_q || eng_done_i;
  assign res_now   = eng_done_i ? result_i : dout_q;
  assign idle      = !eng_busy_i && kv_ready_i;

  // ==========================================================================
  // Read mux
  // ==========================================================================
  always_comb begin
    rd_data = '0;
    case (word_addr)
      crypto_pkg::ADDR_STATUS:    rd_data[2:0] = {!eng_busy_i, out_valid, idle};
      crypto_pkg::ADDR_KV_CTRL:   rd_data[5:1] = kv_ctrl_q.entry;
      crypto_pkg::ADDR_KV_STATUS: rd_data[3:0] = {kv_err_i, kv_valid_q, kv_ready_i};
      crypto_pkg::ADDR_KEY0:      rd_data = key_q[0];
      crypto_pkg::ADDR_KEY1:      rd_data = key_q[1];
      crypto_pkg::ADDR_KEY2:      rd_data = key_q[2];
      crypto_pkg::ADDR_KEY3:      rd_data = key_q[3];
      crypto_pkg::ADDR_DIN0:      rd_data = din_q[0];
      crypto_pkg::ADDR_DIN1:      rd_data = din_q[1];
      crypto_pkg::ADDR_DOUT0:     rd_data = res_now[31:0];
      crypto_pkg::ADDR_DOUT1:     rd_data = res_now[63:32];
      // CTRL reads as zero
      default:                    rd_data = '0;
    endcase
  end

  // Output read waits for the engine
  assign rsp_o.hold  = rd_en && is_dout && eng_busy_i;
  assign rsp_o.error = req_i.dv && (addr_bad || (req_i.write && ro_hit));
  assign rsp_o.rdata = rd_en ? rd_data : '0;

  // ==========================================================================
  // Register updates
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      case (word_addr)
        crypto_pkg::ADDR_KEY0: key_q[0] <= req_i.wdata;
        crypto_pkg::ADDR_KEY1: key_q[1] <= req_i.wdata;
        crypto_pkg::ADDR_KEY2: key_q[2] <= req_i.wdata;
        crypto_pkg::ADDR_KEY3: key_q[3] <= req_i.wdata;
        crypto_pkg::ADDR_DIN0: din_q[0] <= req_i.wdata;
        crypto_pkg::ADDR_DIN1: din_q[1] <= req_i.wdata;
        default: begin
        end
      endcase
    end
    if (eng_done_i) begin
      dout_q <= result_i;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      ov_q       <= 1'b0;
      kv_valid_q <= 1'b0;
      kv_ctrl_q  <= '0;
    end else begin
      // Next start invalidates the output
      if (start_o) begin
        ov_q <= 1'b0;
      end else if (eng_done_i) begin
        ov_q <= 1'b1;
      end
      // Only a clean key read marks the key valid
      if (kv_ctrl_q.read_en) begin
        kv_valid_q <= 1'b0;
      end else if (kv_done_i && (kv_err_i == crypto_pkg::KV_SUCCESS)) begin
        kv_valid_q <= 1'b1;
      end
      // read_en pulses only while the client is ready
      kv_ctrl_q.read_en <= wr_en && (word_addr == crypto_pkg::ADDR_KV_CTRL) &&
                           req_i.wdata[0] && kv_ready_i;
      if (wr_en && (word_addr == crypto_pkg::ADDR_KV_CTRL)) begin
        kv_ctrl_q.entry <= req_i.wdata[5:1] & ENTRY_MASK;
      end
    end
  end

  assign kv_ctrl_o = kv_ctrl_q;

endmodule

//--- cipher_wrapper.sv
// Accelerator top; host and DMA must not access in the same cycle, such accesses fail on both ports
`timescale 1ns/100ps
module cipher_wrapper #(
  parameter int KV_ENTRIES = 32
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  crypto_pkg::reg_req_t     host_req_i,
  output crypto_pkg::reg_rsp_t     host_rsp_o,
  input  crypto_pkg::reg_req_t     dma_req_i,
  output crypto_pkg::reg_rsp_t     dma_rsp_o,
  output crypto_pkg::kv_read_t     kv_read_o,
  input  crypto_pkg::kv_rd_resp_t  kv_rd_resp_i,
  output logic                     busy_o
);

  logic collision;
  logic host_sel;
  logic dma_sel;
  crypto_pkg::reg_req_t regs_req;
  crypto_pkg::reg_rsp_t regs_rsp;

  crypto_pkg::kv_ctrl_t kv_ctrl;
  crypto_pkg::kv_err_e kv_err;
  crypto_pkg::sideload_key_t sideload;
  logic kv_ready;
  logic kv_done;

  logic start;
  logic decrypt;
  logic [63:0] block;
  logic [127:0] key;
  logic eng_busy;
  logic eng_done;
  logic [63:0] result;

  // ==========================================================================
  // Host/DMA steering
  // ==========================================================================
  assign collision = host_req_i.dv && dma_req_i.dv;
  assign host_sel  = host_req_i.dv && !collision;
  assign dma_sel   = dma_req_i.dv && !collision;

  // Collision blocks both, so no register sees it
  assign regs_req.dv    = host_sel || dma_sel;
  assign regs_req.write = dma_sel ? dma_req_i.write : host_req_i.write;
  assign regs_req.addr  = dma_sel ? dma_req_i.addr : host_req_i.addr;
  assign regs_req.wdata = dma_sel ? dma_req_i.wdata : host_req_i.wdata;

  assign host_rsp_o.hold  = host_sel && regs_rsp.hold;
  assign host_rsp_o.error = (host_sel && regs_rsp.error) || collision;
  assign host_rsp_o.rdata = host_sel ? regs_rsp.rdata : '0;

  assign dma_rsp_o.hold  = dma_sel && regs_rsp.hold;
  assign dma_rsp_o.error = (dma_sel && regs_rsp.error) || collision;
  assign dma_rsp_o.rdata = dma_sel ? regs_rsp.rdata : '0;

  // Engine running or key fetch in flight
  assign busy_o = eng_busy || !kv_ready;

  cipher_regs #(
    .KV_ENTRIES(KV_ENTRIES)
  ) u_regs (
    .clk        (clk),
    .reset_n    (reset_n),
    .req_i      (regs_req),
    .rsp_o      (regs_rsp),
    .kv_ctrl_o  (kv_ctrl),
    .kv_ready_i (kv_ready),
    .kv_done_i  (kv_done),
    .kv_err_i   (kv_err),
    .sideload_i (sideload),
    .start_o    (start),
    .decrypt_o  (decrypt),
    .block_o    (block),
    .key_o      (key),
    .eng_busy_i (eng_busy),
    .eng_done_i (eng_done),
    .result_i   (result)
  );

  key_read_client u_kv_client (
    .clk        (clk),
    .reset_n    (reset_n),
    .ctrl_i     (kv_ctrl),
    .kv_read_o  (kv_read_o),
    .kv_resp_i  (kv_rd_resp_i),
    .ready_o    (kv_ready),
    .done_o     (kv_done),
    .error_o    (kv_err),
    .sideload_o (sideload)
  );

  xtea_core u_xtea (
    .clk       (clk),
    .reset_n   (reset_n),
    .start_i   (start),
    .decrypt_i (decrypt),
    .block_i   (block),
    .key_i     (key),
    .busy_o    (eng_busy),
    .done_o    (eng_done),
    .result_o  (result)
  );

endmodule

//--- crypto_pkg.sv
// Shared XTEA accelerator definitions; register map fixed to 6-bit byte addresses, 32-bit words
package crypto_pkg;

  // ==========================================================================
  // Widths and algorithm constants
  // ==========================================================================
  localparam int REG_ADDR_W  = 6;
  localparam int DATA_W      = 32;
  localparam int KEY_WORDS   = 4;
  localparam int KV_ENTRY_W  = 5;
  localparam int XTEA_ROUNDS = 32;
  localparam logic [31:0] XTEA_DELTA = 32'h9e37_79b9;

  // Key vault answers this many cycles after rd_en
  localparam int KV_LATENCY = 1;

  // ==========================================================================
  // Register byte offsets
  // ==========================================================================
  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL      = 6'h00;
  localparam logic [REG_ADDR_W-1:0] ADDR_STATUS    = 6'h04;
  localparam logic [REG_ADDR_W-1:0] ADDR_KV_CTRL   = 6'h08;
  localparam logic [REG_ADDR_W-1:0] ADDR_KV_STATUS = 6'h0c;
  localparam logic [REG_ADDR_W-1:0] ADDR_KEY0      = 6'h10;
  localparam logic [REG_ADDR_W-1:0] ADDR_KEY1      = 6'h14;
  localparam logic [REG_ADDR_W-1:0] ADDR_KEY2      = 6'h18;
  localparam logic [REG_ADDR_W-1:0] ADDR_KEY3      = 6'h1c;
  localparam logic [REG_ADDR_W-1:0] ADDR_DIN0      = 6'h20;
  localparam logic [REG_ADDR_W-1:0] ADDR_DIN1      = 6'h24;
  localparam logic [REG_ADDR_W-1:0] ADDR_DOUT0     = 6'h28;
  localparam logic [REG_ADDR_W-1:0] ADDR_DOUT1     = 6'h2c;
  // First unmapped offset
  localparam logic [REG_ADDR_W-1:0] ADDR_LIMIT     = 6'h30;

  // Key read outcome
  typedef enum logic [1:0] {
    KV_SUCCESS   = 2'b00,
    KV_READ_FAIL = 2'b01
  } kv_err_e;

  // ==========================================================================
  // Bus and side-band structs
  // ==========================================================================
  typedef struct packed {
    logic                  dv;
    logic                  write;
    logic [REG_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
  } reg_req_t;

  typedef struct packed {
    logic              hold;
    logic              error;
    logic [DATA_W-1:0] rdata;
  } reg_rsp_t;

  typedef struct packed {
    logic                  rd_en;
    logic [KV_ENTRY_W-1:0] entry;
    logic [1:0]            offset;
  } kv_read_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              error;
  } kv_rd_resp_t;

  typedef struct packed {
    logic                  read_en;
    logic [KV_ENTRY_W-1:0] entry;
  } kv_ctrl_t;

  // Word i of key is XTEA k[i]
  typedef struct packed {
    logic                               valid;
    logic [KEY_WORDS-1:0][DATA_W-1:0]   key;
  } sideload_key_t;

endpackage

//--- filelist.f
crypto_pkg.sv
key_read_client.sv
xtea_core.sv
cipher_regs.sv
cipher_wrapper.sv
tb_cipher.sv

//--- key_read_client.sv
// Key vault read client; assumes vault always answers KV_LATENCY cycles after rd_en, no stall
`timescale 1ns/100ps
module key_read_client (
  input  logic                       clk,
  input  logic                       reset_n,
  input  crypto_pkg::kv_ctrl_t       ctrl_i,
  output crypto_pkg::kv_read_t       kv_read_o,
  input  crypto_pkg::kv_rd_resp_t    kv_resp_i,
  output logic                       ready_o,
  output logic                       done_o,
  output crypto_pkg::kv_err_e        error_o,
  output crypto_pkg::sideload_key_t  sideload_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_DRAIN
  } state_e;

  state_e state_q;
  logic [1:0] off_q;
  logic [crypto_pkg::KV_ENTRY_W-1:0] entry_q;
  logic err_q;
  logic valid_q;
  logic done_q;
  crypto_pkg::kv_err_e code_q;
  logic [crypto_pkg::KEY_WORDS-1:0][crypto_pkg::DATA_W-1:0] key_q;

  // Outstanding request tracker, one stage per cycle of vault latency
  logic [crypto_pkg::KV_LATENCY-1:0] pend_vld;
  logic [crypto_pkg::KV_LATENCY-1:0][1:0] pend_off;
  logic resp_vld;
  logic [1:0] resp_off;
  logic resp_last;
  logic fail;

  // Vault words arrive big-endian relative to the engine
  function automatic logic [31:0] byte_swap(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  assign kv_read_o.rd_en  = (state_q == ST_REQ);
  assign kv_read_o.entry  = entry_q;
  assign kv_read_o.offset = off_q;

  assign resp_vld  = pend_vld[crypto_pkg::KV_LATENCY-1];
  assign resp_off  = pend_off[crypto_pkg::KV_LATENCY-1];
  assign resp_last = resp_vld && (resp_off == 2'(crypto_pkg::KEY_WORDS - 1));
  // Error on any word so far, including the one now arriving
  assign fail      = err_q || (resp_vld && kv_resp_i.error);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pend_vld <= '0;
      pend_off <= '0;
    end else begin
      pend_vld[0] <= kv_read_o.rd_en;
      pend_off[0] <= off_q;
      for (int i = 1; i < crypto_pkg::KV_LATENCY; i++) begin
        pend_vld[i] <= pend_vld[i-1];
        pend_off[i] <= pend_off[i-1];
      end
    end
  end

  // ==========================================================================
  // Sequencer
  // ==========================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= ST_IDLE;
      off_q   <= '0;
      entry_q <= '0;
      err_q   <= 1'b0;
      valid_q <= 1'b0;
      done_q  <= 1'b0;
      code_q  <= crypto_pkg::KV_SUCCESS;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          // New read drops the previous key
          if (ctrl_i.read_en) begin
            state_q <= ST_REQ;
            off_q   <= '0;
            entry_q <= ctrl_i.entry;
            err_q   <= 1'b0;
            valid_q <= 1'b0;
            code_q  <= crypto_pkg::KV_SUCCESS;
          end
        end
        ST_REQ: begin
          off_q <= off_q + 2'd1;
          if (off_q == 2'(crypto_pkg::KEY_WORDS - 1)) begin
            state_q <= ST_DRAIN;
          end
        end
        default: begin
          // Waiting for the last word
        end
      endcase
      if (resp_vld && kv_resp_i.error) begin
        err_q <= 1'b1;
      end
      if (resp_last) begin
        state_q <= ST_IDLE;
        done_q  <= 1'b1;
        valid_q <= !fail;
        code_q  <= fail ? crypto_pkg::KV_READ_FAIL : crypto_pkg::KV_SUCCESS;
      end
    end
  end

  // Key words, cleared to zero on a failed read
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_q <= '0;
    end else if (resp_last && fail) begin
      key_q <= '0;
    end else if (resp_vld) begin
      key_q[resp_off] <= byte_swap(kv_resp_i.data);
    end
  end

  assign ready_o          = (state_q == ST_IDLE);
  assign done_o           = done_q;
  assign error_o          = code_q;
  assign sideload_o.valid = valid_q;
  assign sideload_o.key   = key_q;

endmodule

//--- tb_cipher.sv
// Directed testbench; vault model answers one cycle after rd_en, entries 7 and 19 return errors
`timescale 1ns/100ps
module tb_cipher;

  localparam int TIMEOUT = 200;

  logic clk;
  logic reset_n;
  crypto_pkg::reg_req_t    host_req;
  crypto_pkg::reg_rsp_t    host_rsp;
  crypto_pkg::reg_req_t    dma_req;
  crypto_pkg::reg_rsp_t    dma_rsp;
  crypto_pkg::kv_read_t    kv_read;
  crypto_pkg::kv_rd_resp_t kv_resp;
  logic busy;

  // Stimulus state
  logic [31:0]  lfsr;
  logic [31:0]  kv_table [32][4];
  logic         kv_bad [32];
  logic [127:0] sw_key;
  logic [63:0]  last_result;

  cipher_wrapper #(
    .KV_ENTRIES(32)
  ) dut0 (
    .clk          (clk),
    .reset_n      (reset_n),
    .host_req_i   (host_req),
    .host_rsp_o   (host_rsp),
    .dma_req_i    (dma_req),
    .dma_rsp_o    (dma_rsp),
    .kv_read_o    (kv_read),
    .kv_rd_resp_i (kv_resp),
    .busy_o       (busy)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==========================================================================
  // Key vault model
  // ==========================================================================
  // Answers one cycle after rd_en
  // Whole entry shares one error flag
  always @(posedge clk) begin
    if (kv_read.rd_en) begin
      kv_resp.data  <= kv_table[kv_read.entry][kv_read.offset];
      kv_resp.error <= kv_bad[kv_read.entry];
    end else begin
      kv_resp <= '0;
    end
  end

  task automatic fill_vault();
    for (int e = 0; e < 32; e++) begin
      for (int o = 0; o < 4; o++) begin
        // Pattern mixes entry and offset
        kv_table[e][o] = 32'h5c3a_9e17 ^ (32'(e) * 32'h0101_0081) ^ (32'(o) << 27) ^
                         (32'(o) * 32'h0003_0500);
      end
      kv_bad[e] = (e == 7) || (e == 19);
    end
  endtask

  // ==========================================================================
  // Reporting and compares
  // ==========================================================================
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_rsp(input string sig, input string what,
                           input crypto_pkg::reg_rsp_t got,
                           input crypto_pkg::reg_rsp_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch %s (%s): got 0x%h expected 0x%h",
                              sig, what, got, exp));
    end
  endtask

  task automatic check_kv_read(input crypto_pkg::kv_read_t got,
                               input crypto_pkg::kv_read_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch kv_read_o: got 0x%h expected 0x%h", got, exp));
    end
  endtask

  task automatic check_kv_err(input crypto_pkg::kv_err_e got,
                              input crypto_pkg::kv_err_e exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch KV_STATUS error code: got 0x%h expected 0x%h",
                              got, exp));
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Mismatch busy_o: got 0x%h expected 0x%h", got, exp));
    end
  endtask

  // ==========================================================================
  // Reference models
  // ==========================================================================
  // Galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic draw_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_step(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] reverse_bytes(input logic [31:0] w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // Textbook XTEA with v0 in the low word and k[i] at key bits 32*i
  function automatic logic [63:0] xtea_model(input logic dec, input logic [63:0] blk,
                                             input logic [127:0] key);
    logic [31:0] v0;
    logic [31:0] v1;
    logic [31:0] sum;
    logic [31:0] k [4];
    v0 = blk[31:0];
    v1 = blk[63:32];
    for (int i = 0; i < 4; i++) begin
      k[i] = key[32*i +: 32];
    end
    // Delta times 32 modulo 2^32
    sum = dec ? 32'hc6ef_3720 : 32'h0;
    for (int r = 0; r < 32; r++) begin
      if (dec) begin
        v1  = v1 - ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[(sum >> 11) & 3]));
        sum = sum - 32'h9e37_79b9;
        v0  = v0 - ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum & 3]));
      end else begin
        v0  = v0 + ((((v1 << 4) ^ (v1 >> 5)) + v1) ^ (sum + k[sum & 3]));
        sum = sum + 32'h9e37_79b9;
        v1  = v1 + ((((v0 << 4) ^ (v0 >> 5)) + v0) ^ (sum + k[(sum >> 11) & 3]));
      end
    end
    return {v1, v0};
  endfunction

  // ==========================================================================
  // Register port access
  // ==========================================================================
  function automatic string port_name(input logic use_dma);
    return use_dma ? "dma_rsp_o" : "host_rsp_o";
  endfunction

  // Request held until hold reads low at a falling edge
  task automatic bus_access(input logic use_dma, input logic wr, input logic [5:0] addr,
                            input logic [31:0] wdata, output crypto_pkg::reg_rsp_t rsp,
                            output int held);
    crypto_pkg::reg_req_t req;
    req.dv    = 1'b1;
    req.write = wr;
    req.addr  = addr;
    req.wdata = wdata;
    held = 0;
    @(posedge clk);
    if (use_dma) begin
      dma_req <= req;
    end else begin
      host_req <= req;
    end
    @(negedge clk);
    rsp = use_dma ? dma_rsp : host_rsp;
    while (rsp.hold) begin
      held++;
      if (held > TIMEOUT) begin
        stop_on_error($sformatf("Timeout: access to 0x%h stayed on hold", addr));
      end
      @(negedge clk);
      rsp = use_dma ? dma_rsp : host_rsp;
    end
    // Access completes on this edge
    @(posedge clk);
    if (use_dma) begin
      dma_req.dv <= 1'b0;
    end else begin
      host_req.dv <= 1'b0;
    end
  endtask

  task automatic write_reg(input logic use_dma, input logic [5:0] addr,
                           input logic [31:0] data);
    crypto_pkg::reg_rsp_t rsp;
    int held;
    bus_access(use_dma, 1'b1, addr, data, rsp, held);
    check_rsp(port_name(use_dma), $sformatf("write 0x%h", addr), rsp, '0);
  endtask

  task automatic read_expect(input logic use_dma, input logic [5:0] addr,
                             input logic [31:0] data, input string what);
    crypto_pkg::reg_rsp_t rsp;
    crypto_pkg::reg_rsp_t exp;
    int held;
    exp       = '0;
    exp.rdata = data;
    bus_access(use_dma, 1'b0, addr, 32'h0, rsp, held);
    check_rsp(port_name(use_dma), what, rsp, exp);
  endtask

  task automatic read_reg(input logic use_dma, input logic [5:0] addr,
                          output logic [31:0] data);
    crypto_pkg::reg_rsp_t rsp;
    int held;
    bus_access(use_dma, 1'b0, addr, 32'h0, rsp, held);
    if (rsp.error) begin
      stop_on_error($sformatf("Read of register 0x%h returned an error", addr));
    end
    data = rsp.rdata;
  endtask

  task automatic load_key(input logic use_dma, input logic [127:0] key);
    write_reg(use_dma, crypto_pkg::ADDR_KEY0, key[31:0]);
    write_reg(use_dma, crypto_pkg::ADDR_KEY1, key[63:32]);
    write_reg(use_dma, crypto_pkg::ADDR_KEY2, key[95:64]);
    write_reg(use_dma, crypto_pkg::ADDR_KEY3, key[127:96]);
  endtask

  // Poll STATUS until output_valid
  task automatic wait_output(input logic use_dma);
    logic [31:0] st;
    int tries;
    tries = 0;
    read_reg(use_dma, crypto_pkg::ADDR_STATUS, st);
    while (!st[1]) begin
      tries++;
      if (tries > TIMEOUT) begin
        stop_on_error("Timeout: STATUS output_valid never rose");
      end
      read_reg(use_dma, crypto_pkg::ADDR_STATUS, st);
    end
  endtask

  task automatic run_block(input logic use_dma, input logic dec, input logic [63:0] blk,
                           input logic [127:0] key, output logic [63:0] res);
    res = xtea_model(dec, blk, key);
    write_reg(use_dma, crypto_pkg::ADDR_DIN0, blk[31:0]);
    write_reg(use_dma, crypto_pkg::ADDR_DIN1, blk[63:32]);
    write_reg(use_dma, crypto_pkg::ADDR_CTRL, {30'b0, dec, 1'b1});
    wait_output(use_dma);
    read_expect(use_dma, crypto_pkg::ADDR_DOUT0, res[31:0], "DOUT0");
    read_expect(use_dma, crypto_pkg::ADDR_DOUT1, res[63:32], "DOUT1");
    last_result = res;
  endtask

  // Start a vault read, follow the four requests and wait for ready
  task automatic kv_fetch(input logic [4:0] entry, input logic expect_fail);
    crypto_pkg::kv_read_t exp_req;
    logic [31:0] st;
    int waited;
    write_reg(1'b0, crypto_pkg::ADDR_KV_CTRL, {26'b0, entry, 1'b1});
    waited = 0;
    @(negedge clk);
    while (!kv_read.rd_en) begin
      waited++;
      if (waited > TIMEOUT) begin
        stop_on_error("Timeout: no key vault request after KV_CTRL write");
      end
      @(negedge clk);
    end
    for (int off = 0; off < 4; off++) begin
      exp_req.rd_en  = 1'b1;
      exp_req.entry  = entry;
      exp_req.offset = 2'(off);
      check_kv_read(kv_read, exp_req);
      // Key fetch in flight
      check_busy(busy, 1'b1);
      @(negedge clk);
    end
    waited = 0;
    read_reg(1'b0, crypto_pkg::ADDR_KV_STATUS, st);
    while (!st[0]) begin
      waited++;
      if (waited > TIMEOUT) begin
        stop_on_error("Timeout: key read client never returned to ready");
      end
      read_reg(1'b0, crypto_pkg::ADDR_KV_STATUS, st);
    end
    check_kv_err(crypto_pkg::kv_err_e'(st[3:2]),
                 expect_fail ? crypto_pkg::KV_READ_FAIL : crypto_pkg::KV_SUCCESS);
    // Failed read shows code 01 with valid low
    // Good read shows valid high
    read_expect(1'b0, crypto_pkg::ADDR_KV_STATUS, expect_fail ? 32'h5 : 32'h3, "KV_STATUS");
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================
  task automatic sw_key_roundtrip();
    logic [63:0] plain;
    logic [63:0] ctext;
    logic [63:0] back;
    plain  = 64'h0123_4567_89ab_cdef;
    sw_key = 128'h0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0;
    // idle and input_ready only
    read_expect(1'b0, crypto_pkg::ADDR_STATUS, 32'h5, "STATUS after reset");
    read_expect(1'b0, crypto_pkg::ADDR_KV_STATUS, 32'h1, "KV_STATUS after reset");
    load_key(1'b0, sw_key);
    run_block(1'b0, 1'b0, plain, sw_key, ctext);
    read_expect(1'b0, crypto_pkg::ADDR_STATUS, 32'h7, "STATUS after done");
    run_block(1'b0, 1'b1, ctext, sw_key, back);
    read_expect(1'b0, crypto_pkg::ADDR_DOUT0, plain[31:0], "DOUT0 restored plaintext");
    read_expect(1'b0, crypto_pkg::ADDR_DOUT1, plain[63:32], "DOUT1 restored plaintext");
  endtask

  task automatic kv_sideload_read();
    logic [127:0] key;
    logic [63:0] res;
    kv_fetch(5'd5, 1'b0);
    for (int i = 0; i < 4; i++) begin
      key[32*i +: 32] = reverse_bytes(kv_table[5][i]);
    end
    run_block(1'b0, 1'b0, 64'hfedc_ba98_7654_3210, key, res);
  endtask

  task automatic kv_error_read();
    logic [63:0] res;
    kv_fetch(5'd7, 1'b1);
    // Software key is back in use
    run_block(1'b1, 1'b0, 64'h1122_3344_5566_7788, sw_key, res);
  endtask

  task automatic collision_and_bad_access();
    crypto_pkg::reg_req_t req_h;
    crypto_pkg::reg_req_t req_d;
    crypto_pkg::reg_rsp_t exp_err;
    crypto_pkg::reg_rsp_t host_got;
    crypto_pkg::reg_rsp_t dma_got;
    crypto_pkg::reg_rsp_t rsp;
    int held;
    exp_err       = '0;
    exp_err.error = 1'b1;
    req_h = {1'b1, 1'b1, crypto_pkg::ADDR_KEY0, 32'hdead_beef};
    req_d = {1'b1, 1'b1, crypto_pkg::ADDR_KEY0, 32'h1357_9bdf};
    // Both ports in one cycle
    @(posedge clk);
    host_req <= req_h;
    dma_req  <= req_d;
    @(negedge clk);
    host_got = host_rsp;
    dma_got  = dma_rsp;
    @(posedge clk);
    host_req.dv <= 1'b0;
    dma_req.dv  <= 1'b0;
    check_rsp("host_rsp_o", "collision", host_got, exp_err);
    check_rsp("dma_rsp_o", "collision", dma_got, exp_err);
    read_expect(1'b0, crypto_pkg::ADDR_KEY0, sw_key[31:0], "KEY0 after collision");
    // Unmapped and read-only targets
    bus_access(1'b0, 1'b0, 6'h30, 32'h0, rsp, held);
    check_rsp("host_rsp_o", "read 0x30", rsp, exp_err);
    bus_access(1'b1, 1'b1, 6'h3c, 32'hffff_ffff, rsp, held);
    check_rsp("dma_rsp_o", "write 0x3c", rsp, exp_err);
    bus_access(1'b0, 1'b1, crypto_pkg::ADDR_DOUT0, 32'h0bad_f00d, rsp, held);
    check_rsp("host_rsp_o", "write DOUT0", rsp, exp_err);
    read_expect(1'b0, crypto_pkg::ADDR_DOUT0, last_result[31:0], "DOUT0 after bad write");
  endtask

  task automatic held_dout_read();
    logic [63:0] blk;
    logic [63:0] exp;
    crypto_pkg::reg_rsp_t rsp;
    crypto_pkg::reg_rsp_t exp_rsp;
    int held;
    blk = 64'h0a0b_0c0d_1020_3040;
    exp = xtea_model(1'b0, blk, sw_key);
    // Nothing running yet
    @(negedge clk);
    check_busy(busy, 1'b0);
    write_reg(1'b0, crypto_pkg::ADDR_DIN0, blk[31:0]);
    write_reg(1'b0, crypto_pkg::ADDR_DIN1, blk[63:32]);
    write_reg(1'b0, crypto_pkg::ADDR_CTRL, 32'h1);
    // Engine runs from the start edge on
    @(negedge clk);
    check_busy(busy, 1'b1);
    bus_access(1'b0, 1'b0, crypto_pkg::ADDR_DOUT0, 32'h0, rsp, held);
    if (held == 0) begin
      stop_on_error("DOUT0 read right after start was not held");
    end
    exp_rsp       = '0;
    exp_rsp.rdata = exp[31:0];
    check_rsp("host_rsp_o", "held DOUT0 read", rsp, exp_rsp);
    last_result = exp;
  endtask

  task automatic random_blocks();
    logic [127:0] key;
    logic [63:0] blk;
    logic [63:0] res;
    logic [31:0] w;
    logic use_dma;
    logic dec;
    for (int n = 0; n < 10; n++) begin
      use_dma = ((n % 2) == 1);
      dec     = (((n / 2) % 2) == 1);
      for (int i = 0; i < 4; i++) begin
        draw_word(w);
        key[32*i +: 32] = w;
      end
      draw_word(w);
      blk[31:0] = w;
      draw_word(w);
      blk[63:32] = w;
      load_key(use_dma, key);
      run_block(use_dma, dec, blk, key, res);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    lfsr     = 32'h4ea7366f;
    reset_n  = 1'b0;
    host_req = '0;
    dma_req  = '0;
    kv_resp  = '0;
    sw_key   = '0;
    last_result = '0;
    fill_vault();
    repeat (8) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);
    sw_key_roundtrip();
    kv_sideload_read();
    kv_error_read();
    collision_and_bad_access();
    held_dout_read();
    random_blocks();
    $display("Verification passed");
    $finish;
  end

endmodule

//--- xtea_core.sv
// Iterative XTEA, one full round per clock; start is ignored while busy, result held until next start
`timescale 1ns/100ps
module xtea_core (
  input  logic         clk,
  input  logic         reset_n,
  input  logic         start_i,
  input  logic         decrypt_i,
  input  logic [63:0]  block_i,
  input  logic [127:0] key_i,
  output logic         busy_o,
  output logic         done_o,
  output logic [63:0]  result_o
);

  localparam int RND_W = $clog2(crypto_pkg::XTEA_ROUNDS);
  // Decrypt starts from the sum reached after the last encrypt round
  localparam logic [31:0] SUM_DEC = 32'(crypto_pkg::XTEA_DELTA * crypto_pkg::XTEA_ROUNDS);

  logic launch;
  logic busy_q;
  logic done_q;
  logic [RND_W-1:0] rnd_q;
  logic dec_q;
  logic [31:0] v0_q;
  logic [31:0] v1_q;
  logic [31:0] sum_q;
  logic [crypto_pkg::KEY_WORDS-1:0][31:0] key_q;

  // Round inputs: fresh operands on launch, else the running state
  logic dec_s;
  logic [31:0] v0_s;
  logic [31:0] v1_s;
  logic [31:0] sum_s;
  logic [crypto_pkg::KEY_WORDS-1:0][31:0] key_s;
  logic [31:0] v0_n;
  logic [31:0] v1_n;
  logic [31:0] sum_n;

  function automatic logic [31:0] mix(input logic [31:0] v, input logic [31:0] s,
                                      input logic [31:0] k);
    return (((v << 4) ^ (v >> 5)) + v) ^ (s + k);
  endfunction

  assign launch = start_i && !busy_q;

  assign dec_s = launch ? decrypt_i : dec_q;
  assign v0_s  = launch ? block_i[31:0] : v0_q;
  assign v1_s  = launch ? block_i[63:32] : v1_q;
  assign sum_s = launch ? (decrypt_i ? SUM_DEC : 32'd0) : sum_q;
  assign key_s = launch ? key_i : key_q;

  // ==========================================================================
  // One full round, both half-rounds
  // ==========================================================================
  always_comb begin
    if (dec_s) begin
      sum_n = sum_s - crypto_pkg::XTEA_DELTA;
      v1_n  = v1_s - mix(v0_s, sum_s, key_s[sum_s[12:11]]);
      v0_n  = v0_s - mix(v1_n, sum_n, key_s[sum_n[1:0]]);
    end else begin
      sum_n = sum_s + crypto_pkg::XTEA_DELTA;
      v0_n  = v0_s + mix(v1_s, sum_s, key_s[sum_s[1:0]]);
      v1_n  = v1_s + mix(v0_n, sum_n, key_s[sum_n[12:11]]);
    end
  end

  // Datapath, first round taken on the launch edge
  always_ff @(posedge clk) begin
    if (launch) begin
      dec_q <= decrypt_i;
      key_q <= key_i;
    end
    if (launch || busy_q) begin
      v0_q  <= v0_n;
      v1_q  <= v1_n;
      sum_q <= sum_n;
    end
  end

  // Round counter counts completed rounds
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      rnd_q  <= '0;
    end else begin
      done_q <= 1'b0;
      if (launch) begin
        busy_q <= 1'b1;
        rnd_q  <= RND_W'(1);
      end else if (busy_q) begin
        rnd_q <= rnd_q + RND_W'(1);
        if (rnd_q == RND_W'(crypto_pkg::XTEA_ROUNDS - 1)) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  assign busy_o   = busy_q;
  assign done_o   = done_q;
  assign result_o = {v1_q, v0_q};

endmodule
